//--- dv/llc_front_assert.sv
`timescale 1ns/10ps

module llc_front_assert import llc_ctrl_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    act_valid,
    input action_t act,
    input logic    rst_tb_ready,
    input logic    rsp_in_ready,
    input logic    req_in_ready,
    input logic    dma_req_in_ready,
    input logic    wb_ack
);

    logic [3:0] readies;

    assign readies = {rst_tb_ready, rsp_in_ready, req_in_ready, dma_req_in_ready};

    act_not_none: assert property (@(posedge clk) disable iff (!rst)
        act_valid |-> act != act_none) else $error("act_valid high with no action");

    // Only one channel is taken per cycle.
    one_ready: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(readies)) else $error("more than one ready high");

    ack_pulse: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |=> !wb_ack) else $error("wb_ack longer than one cycle");

    no_ready_in_reset: assert property (@(posedge clk)
        !rst |-> readies == 4'b0) else $error("ready given during reset");

endmodule

//--- dv/llc_front_tb.sv
`timescale 1ns/10ps
`include "llc_front_config.svh"

module llc_front_tb import llc_msg_pkg::*; import llc_ctrl_pkg::*; ();

    localparam int NUM_VECS = 20;

    logic clk, rst;
    logic rst_tb_valid, rsp_in_valid, req_in_valid, dma_req_in_valid;
    logic rst_tb_ready, rsp_in_ready, req_in_ready, dma_req_in_ready;
    payload_t rst_tb_payload, rsp_in_payload, req_in_payload, dma_req_in_payload;
    logic recall_pending, recall_valid, dma_read_pending, dma_write_pending;
    logic req_stall, core_ready, req_refuse, op_done;
    logic act_valid;
    action_t act;
    payload_t act_payload;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    wb_addr_t wb_adr;
    payload_t wb_dat_i, wb_dat_o;

    logic [15:0] vecs [0:NUM_VECS-1];
    int errors = 0;
    int exp_req_cnt = 0;
    int exp_replay_cnt = 0;
    payload_t held_payload, rd;
    int lat;
    logic [3:0] seen; // Channels whose ready was up at the last falling edge.

    llc_front_top DUT (.*);

    bind llc_front_top llc_front_assert u_assert (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Channel readies that an action must pulse.
    function automatic logic [3:0] ready_for(input action_t a);
        case (a)
            act_rst_get:          return 4'b1000;
            act_rsp_get:          return 4'b0100;
            act_req_get:          return 4'b0010;
            act_dma_req_get,
            act_dma_write_resume: return 4'b0001;
            default:              return 4'b0000;
        endcase
    endfunction

    function automatic payload_t payload_for(input action_t a);
        case (a)
            act_rst_get:          return rst_tb_payload;
            act_rsp_get:          return rsp_in_payload;
            act_req_get:          return req_in_payload;
            act_req_replay:       return held_payload;
            act_dma_req_get,
            act_dma_write_resume: return dma_req_in_payload;
            default:              return '0;
        endcase
    endfunction

    // A source drops its valid once it has seen ready on a rising edge.
    task automatic release_taken();
        logic [3:0] rdy;
        logic [3:0] vld;
        rdy = {rst_tb_ready, rsp_in_ready, req_in_ready, dma_req_in_ready};
        vld = {rst_tb_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} & ~seen;
        if ((rdy & ~vld) != 4'b0) begin
            report_failure($sformatf("Ready given with no message on channels %b",
                rdy & ~vld));
        end
        {rst_tb_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} = vld;
        seen = rdy;
    endtask

    task automatic wait_act(output int cycles);
        cycles = 0;
        while (!act_valid && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!act_valid) report_failure("Timed out waiting for act_valid");
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("act_valid", 32'(act_valid), 32'h0);
            check("readies", 32'({rst_tb_ready, rsp_in_ready, req_in_ready,
                dma_req_in_ready}), 32'h0);
        end
    endtask

    // Lets the remaining channels be taken, then waits for silence.
    task automatic drain();
        int i;
        i = 0;
        while ((rst_tb_valid || rsp_in_valid || req_in_valid || dma_req_in_valid) && i < 20) begin
            @(negedge clk);
            release_taken();
            i++;
        end
        if (i >= 20) report_failure("Timed out draining the channels");
        repeat (3) begin
            @(negedge clk);
            release_taken();
        end
        check("act_valid", 32'(act_valid), 32'h0);
    endtask

    task automatic wb_access(input logic we, input wb_addr_t adr, input payload_t data);
        int i;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_i = data;
        i = 0;
        do begin
            @(negedge clk);
            i++;
        end while (!wb_ack && i < 10);
        if (!wb_ack) report_failure("Timed out waiting for wb_ack");
        rd = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic run_vector(input logic [15:0] v);
        action_t exp_act;
        exp_act = action_t'(v[3:0]);
        rst_tb_payload = $urandom;
        rsp_in_payload = $urandom;
        req_in_payload = $urandom;
        dma_req_in_payload = $urandom;
        {rst_tb_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} = v[15:12];
        if (v[13]) exp_req_cnt++; // Every request offered is taken once.
        {recall_pending, recall_valid, dma_read_pending, dma_write_pending} = v[11:8];
        req_stall = v[5];
        core_ready = v[4];
        if (!core_ready) begin
            expect_quiet(4); // Back-pressure holds everything.
            core_ready = 1'b1;
        end
        if (exp_act == act_none) begin
            expect_quiet(4);
        end else begin
            wait_act(lat);
            check("latency", 32'(lat), 32'd2);
            check("act", 32'(act), 32'(exp_act));
            check("readies", 32'({rst_tb_ready, rsp_in_ready, req_in_ready,
                dma_req_in_ready}), 32'(ready_for(exp_act)));
            check("act_payload", act_payload, payload_for(exp_act));
        end
        {recall_pending, recall_valid, dma_read_pending, dma_write_pending} = 4'b0;
        req_stall = 1'b0;
        release_taken();
        drain();
    endtask

    task automatic run_stall(input payload_t cmd, input action_t resume, input int st);
        wb_access(1'b1, `LLC_REG_CMD, cmd);
        wait_act(lat);
        repeat (3) begin
            check("act", 32'(act), 32'(resume));
            @(negedge clk);
        end
        wb_access(1'b0, `LLC_REG_STATUS, '0);
        check("status", 32'(rd[1:0]), 32'(st));
        wb_access(1'b1, `LLC_REG_CMD, 32'h3 ^ cmd); // Ignored while stalled.
        wb_access(1'b0, `LLC_REG_STATUS, '0);
        check("status", 32'(rd[1:0]), 32'(st));
        op_done = 1'b1;
        @(negedge clk);
        op_done = 1'b0;
        repeat (3) @(negedge clk);
        check("act_valid", 32'(act_valid), 32'h0);
        wb_access(1'b0, `LLC_REG_STATUS, '0);
        check("status", 32'(rd[1:0]), 32'h0);
    endtask

    initial begin
        void'($urandom(410));
        rst = 1'b0;
        {rst_tb_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} = 4'b0;
        rst_tb_payload = '0;
        rsp_in_payload = '0;
        req_in_payload = '0;
        dma_req_in_payload = '0;
        {recall_pending, recall_valid, dma_read_pending, dma_write_pending} = 4'b0;
        req_stall = 1'b0;
        core_ready = 1'b1;
        req_refuse = 1'b0;
        op_done = 1'b0;
        {wb_cyc, wb_stb, wb_we} = 3'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        held_payload = '0;
        seen = 4'b0;
        $readmemh("dv/llc_front_tests.txt", vecs);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        for (int i = 0; i < NUM_VECS; i++) run_vector(vecs[i]);

        run_stall(32'h1, act_flush_resume, 2);
        run_stall(32'h2, act_rst_resume, 1);

        // Refused request is replayed ahead of a new one.
        req_in_payload = $urandom;
        req_in_valid = 1'b1;
        exp_req_cnt++;
        wait_act(lat);
        check("act", 32'(act), 32'(act_req_get));
        held_payload = req_in_payload;
        release_taken();
        req_stall = 1'b1;
        @(negedge clk);
        release_taken();
        req_refuse = 1'b1;
        @(negedge clk);
        req_refuse = 1'b0;
        wb_access(1'b0, `LLC_REG_STATUS, '0);
        check("status", 32'(rd[2:0]), 32'h4);
        req_in_payload = $urandom;
        req_in_valid = 1'b1;
        exp_req_cnt++;
        req_stall = 1'b0;
        wait_act(lat);
        check("act", 32'(act), 32'(act_req_replay));
        check("act_payload", act_payload, held_payload);
        exp_replay_cnt++;
        @(negedge clk);
        check("act", 32'(act), 32'(act_req_get));
        check("act_payload", act_payload, req_in_payload);
        release_taken();
        drain();

        wb_access(1'b0, `LLC_REG_REQ_CNT, '0);
        check("req_cnt", rd, 32'(exp_req_cnt));
        wb_access(1'b0, `LLC_REG_REPLAY_CNT, '0);
        check("replay_cnt", rd, 32'(exp_replay_cnt));

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dv/llc_front_tests.txt
// One vector per line, four hex digits VSRA.
// V {rst_tb,rsp,req,dma} valids, S {recall_pend,recall_valid,dma_rd,dma_wr}, R {0,0,req_stall,core_ready}, A action.
8015
4016
2017
1019
F015
C116
4816
2810
FE13
1D14
FC10
3030
2233
1114
0110
0313
A217
6006
F005
1213

//--- include/llc_front_config.svh
`ifndef LLC_FRONT_CONFIG_SVH
`define LLC_FRONT_CONFIG_SVH

// Widths.
`define LLC_ADDR_W     4
`define LLC_PAYLOAD_W  32
`define LLC_CNT_W      16

// Wishbone register byte offsets.
`define LLC_REG_CMD         4'h0
`define LLC_REG_STATUS      4'h4
`define LLC_REG_REQ_CNT     4'h8
`define LLC_REG_REPLAY_CNT  4'hc

// Command register bits.
`define LLC_CMD_FLUSH_BIT  0
`define LLC_CMD_RST_BIT    1

`endif

//--- llc_front.f
+incdir+include
source/llc_msg_pkg.sv
source/llc_ctrl_pkg.sv
source/llc_input_arbiter.sv
source/llc_stall_tracker.sv
source/llc_wb_regs.sv
source/llc_front_top.sv
dv/llc_front_assert.sv
dv/llc_front_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f llc_front.f \
    --top-module llc_front_tb -o llc_front_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/llc_front_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^All checks passed$"; then
    exit 0
fi
exit 1

//--- source/llc_ctrl_pkg.sv
package llc_ctrl_pkg;

    // One action per cycle towards the cache core.
    typedef enum logic [3:0] {
        act_none             = 4'd0,
        act_rst_resume       = 4'd1,
        act_flush_resume     = 4'd2,
        act_dma_read_resume  = 4'd3,
        act_dma_write_resume = 4'd4,
        act_rst_get          = 4'd5,
        act_rsp_get          = 4'd6,
        act_req_get          = 4'd7,
        act_req_replay       = 4'd8,
        act_dma_req_get      = 4'd9
    } action_t;

    // Encoding is visible in status bits 1 to 0.
    typedef enum logic [1:0] {
        st_idle        = 2'd0,
        st_rst_stall   = 2'd1,
        st_flush_stall = 2'd2
    } stall_state_t;

endpackage

//--- source/llc_front_top.sv
`timescale 1ns/10ps

module llc_front_top import llc_msg_pkg::*; import llc_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rst_tb_valid,
    output logic     rst_tb_ready,
    input  payload_t rst_tb_payload,
    input  logic     rsp_in_valid,
    output logic     rsp_in_ready,
    input  payload_t rsp_in_payload,
    input  logic     req_in_valid,
    output logic     req_in_ready,
    input  payload_t req_in_payload,
    input  logic     dma_req_in_valid,
    output logic     dma_req_in_ready,
    input  payload_t dma_req_in_payload,
    input  logic     recall_pending,
    input  logic     recall_valid,
    input  logic     dma_read_pending,
    input  logic     dma_write_pending,
    input  logic     req_stall,
    input  logic     core_ready,
    input  logic     req_refuse,
    input  logic     op_done,
    output logic     act_valid,
    output action_t  act,
    output payload_t act_payload,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  payload_t wb_dat_i,
    output payload_t wb_dat_o,
    output logic     wb_ack
);

    logic         rst_stall, flush_stall;
    logic         replay_valid;
    payload_t     replay_payload;
    stall_state_t state;
    logic         start_rst, start_flush;

    llc_input_arbiter u_arbiter (
        .clk, .rst,
        .rst_tb_valid, .rsp_in_valid, .req_in_valid, .dma_req_in_valid,
        .rst_tb_ready, .rsp_in_ready, .req_in_ready, .dma_req_in_ready,
        .recall_pending, .recall_valid, .dma_read_pending, .dma_write_pending,
        .req_stall, .core_ready, .rst_stall, .flush_stall, .replay_valid,
        .act_valid, .act
    );

    llc_stall_tracker u_tracker (
        .clk, .rst, .start_rst, .start_flush, .op_done, .req_refuse,
        .act_valid, .act, .req_payload(act_payload),
        .rst_stall, .flush_stall, .replay_valid, .replay_payload, .state
    );

    llc_wb_regs u_regs (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
        .state, .replay_valid, .act_valid, .act, .start_rst, .start_flush
    );

    // Channel payloads stay on their ports until the ready edge.
    always_comb begin
        case (act)
            act_rst_get:          act_payload = rst_tb_payload;
            act_rsp_get:          act_payload = rsp_in_payload;
            act_req_get:          act_payload = req_in_payload;
            act_req_replay:       act_payload = replay_payload;
            act_dma_req_get,
            act_dma_write_resume: act_payload = dma_req_in_payload;
            default:              act_payload = '0; // Resumes carry no message.
        endcase
    end

endmodule

//--- source/llc_input_arbiter.sv
`timescale 1ns/10ps

module llc_input_arbiter import llc_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rst_tb_valid,
    input  logic    rsp_in_valid,
    input  logic    req_in_valid,
    input  logic    dma_req_in_valid,
    output logic    rst_tb_ready,
    output logic    rsp_in_ready,
    output logic    req_in_ready,
    output logic    dma_req_in_ready,
    input  logic    recall_pending,
    input  logic    recall_valid,
    input  logic    dma_read_pending,
    input  logic    dma_write_pending,
    input  logic    req_stall,
    input  logic    core_ready,
    input  logic    rst_stall,
    input  logic    flush_stall,
    input  logic    replay_valid,
    output logic    act_valid,
    output action_t act
);

    logic can_get_rst_tb, can_get_rsp_in, can_get_req_in, can_get_dma_req_in;
    logic recall_pending_q, recall_valid_q;
    logic dma_read_pending_q, dma_write_pending_q;
    logic req_stall_q, core_ready_q;
    logic rst_tb_avail, rsp_in_avail, req_in_avail, dma_req_in_avail;
    logic replay_avail;
    action_t act_next;

    // Sample stage. A channel being acknowledged is not sampled again.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            can_get_rst_tb <= 1'b0;
            can_get_rsp_in <= 1'b0;
            can_get_req_in <= 1'b0;
            can_get_dma_req_in <= 1'b0;
            recall_pending_q <= 1'b0;
            recall_valid_q <= 1'b0;
            dma_read_pending_q <= 1'b0;
            dma_write_pending_q <= 1'b0;
            req_stall_q <= 1'b0;
            core_ready_q <= 1'b0;
        end else begin
            can_get_rst_tb <= rst_tb_valid && !rst_tb_ready;
            can_get_rsp_in <= rsp_in_valid && !rsp_in_ready;
            can_get_req_in <= req_in_valid && !req_in_ready;
            can_get_dma_req_in <= dma_req_in_valid && !dma_req_in_ready;
            recall_pending_q <= recall_pending;
            recall_valid_q <= recall_valid;
            dma_read_pending_q <= dma_read_pending;
            dma_write_pending_q <= dma_write_pending;
            req_stall_q <= req_stall;
            core_ready_q <= core_ready;
        end
    end

    // Sample taken just before the ready edge is stale.
    assign rst_tb_avail = can_get_rst_tb && !rst_tb_ready;
    assign rsp_in_avail = can_get_rsp_in && !rsp_in_ready;
    assign req_in_avail = can_get_req_in && !req_in_ready;
    assign dma_req_in_avail = can_get_dma_req_in && !dma_req_in_ready;

    // Tracker clears the buffer one edge after the replay goes out.
    assign replay_avail = replay_valid && !(act_valid && act == act_req_replay);

    always_comb begin
        act_next = act_none;
        if (recall_pending_q) begin
            if (!recall_valid_q) begin
                if (rsp_in_avail) act_next = act_rsp_get;
            end else if (dma_read_pending_q) begin
                act_next = act_dma_read_resume;
            end else if (dma_write_pending_q) begin
                act_next = act_dma_write_resume;
            end
        end else if (rst_stall) begin
            act_next = act_rst_resume;
        end else if (flush_stall) begin
            act_next = act_flush_resume;
        end else if (rst_tb_avail && !dma_read_pending_q && !dma_write_pending_q) begin
            act_next = act_rst_get;
        end else if (rsp_in_avail) begin
            act_next = act_rsp_get;
        end else if (!req_stall_q && (replay_avail || req_in_avail)) begin
            act_next = replay_avail ? act_req_replay : act_req_get; // Held request first.
        end else if (dma_read_pending_q) begin
            act_next = act_dma_read_resume;
        end else if (dma_write_pending_q) begin
            if (dma_req_in_avail) act_next = act_dma_write_resume; // Needs the DMA data.
        end else if (dma_req_in_avail && !req_stall_q) begin
            act_next = act_dma_req_get;
        end
    end

    // Decision stage, held off while the core pushes back.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            act_valid <= 1'b0;
            act <= act_none;
            rst_tb_ready <= 1'b0;
            rsp_in_ready <= 1'b0;
            req_in_ready <= 1'b0;
            dma_req_in_ready <= 1'b0;
        end else begin
            act_valid <= core_ready_q && act_next != act_none;
            act <= core_ready_q ? act_next : act_none;
            rst_tb_ready <= core_ready_q && act_next == act_rst_get;
            rsp_in_ready <= core_ready_q && act_next == act_rsp_get;
            req_in_ready <= core_ready_q && act_next == act_req_get;
            // A recall write resume takes the DMA request only when one is waiting.
            dma_req_in_ready <= core_ready_q && (act_next == act_dma_req_get ||
                (act_next == act_dma_write_resume && dma_req_in_avail));
        end
    end

endmodule

//--- source/llc_msg_pkg.sv
`include "llc_front_config.svh"

package llc_msg_pkg;

    // Channel payload, passed through to the core without decoding.
    typedef logic [`LLC_PAYLOAD_W-1:0] payload_t;

    // Byte address on the control bus.
    typedef logic [`LLC_ADDR_W-1:0] wb_addr_t;

    typedef logic [`LLC_CNT_W-1:0] event_cnt_t; // Wraps on overflow.

endpackage

//--- source/llc_stall_tracker.sv
`timescale 1ns/10ps

module llc_stall_tracker import llc_msg_pkg::*; import llc_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_rst,
    input  logic         start_flush,
    input  logic         op_done,
    input  logic         req_refuse,
    input  logic         act_valid,
    input  action_t      act,
    input  payload_t     req_payload,
    output logic         rst_stall,
    output logic         flush_stall,
    output logic         replay_valid,
    output payload_t     replay_payload,
    output stall_state_t state
);

    stall_state_t state_next;
    payload_t     last_req_payload;
    logic         req_issued;
    logic         replay_issued;

    assign req_issued = act_valid && (act == act_req_get || act == act_req_replay);
    assign replay_issued = act_valid && act == act_req_replay;

    // Stall FSM.
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start_rst) begin
                    state_next = st_rst_stall; // Reset wins over flush.
                end else if (start_flush) begin
                    state_next = st_flush_stall;
                end
            end
            st_rst_stall, st_flush_stall: begin
                if (op_done) state_next = st_idle;
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    assign rst_stall = state == st_rst_stall;
    assign flush_stall = state == st_flush_stall;

    // Copy of every request sent, in case the core refuses it a cycle later.
    always_ff @(posedge clk) begin
        if (req_issued) last_req_payload <= req_payload;
        if (req_refuse) replay_payload <= last_req_payload;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            replay_valid <= 1'b0;
        end else if (req_refuse) begin
            replay_valid <= 1'b1;
        end else if (replay_issued) begin
            replay_valid <= 1'b0;
        end
    end

endmodule

//--- source/llc_wb_regs.sv
`timescale 1ns/10ps
`include "llc_front_config.svh"

module llc_wb_regs import llc_msg_pkg::*; import llc_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  wb_addr_t     wb_adr,
    input  payload_t     wb_dat_i,
    output payload_t     wb_dat_o,
    output logic         wb_ack,
    input  stall_state_t state,
    input  logic         replay_valid,
    input  logic         act_valid,
    input  action_t      act,
    output logic         start_rst,
    output logic         start_flush
);

    logic       access;
    logic       cmd_write;
    event_cnt_t req_cnt;
    event_cnt_t replay_cnt;
    payload_t   rd_data;

    // Blocked while ack is up so each access is seen once.
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign cmd_write = access && wb_we && wb_adr == `LLC_REG_CMD;

    always_comb begin
        case (wb_adr)
            `LLC_REG_CMD: begin
                // Bits of the operation that is in progress.
                rd_data = payload_t'({state == st_rst_stall, state == st_flush_stall});
            end
            `LLC_REG_STATUS:     rd_data = payload_t'({replay_valid, state});
            `LLC_REG_REQ_CNT:    rd_data = payload_t'(req_cnt);
            `LLC_REG_REPLAY_CNT: rd_data = payload_t'(replay_cnt);
            default:             rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_ack <= 1'b0;
            start_rst <= 1'b0;
            start_flush <= 1'b0;
        end else begin
            wb_ack <= access;
            start_rst <= cmd_write && wb_dat_i[`LLC_CMD_RST_BIT];
            start_flush <= cmd_write && wb_dat_i[`LLC_CMD_FLUSH_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_we) wb_dat_o <= rd_data;
    end

    // Event counters.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_cnt <= '0;
            replay_cnt <= '0;
        end else if (act_valid) begin
            if (act == act_req_get) req_cnt <= req_cnt + 1'b1;
            if (act == act_req_replay) replay_cnt <= replay_cnt + 1'b1;
        end
    end

endmodule
